/* list.f */
+incdir+design
design/fixed_point_pkg.sv
design/prng_pkg.sv
design/delay_line.sv
design/softplus_pwl.sv
design/sqrt_pipe.sv
design/lfsr_noise.sv
design/reparam_combine.sv
design/lambda_sampler_top.sv
testbench/tb_lambda_sampler.sv

/* Bender.yml */
package:
  name: lambda_sampler

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/fixed_point_pkg.sv
      - design/prng_pkg.sv
      - design/delay_line.sv
      - design/softplus_pwl.sv
      - design/sqrt_pipe.sv
      - design/lfsr_noise.sv
      - design/reparam_combine.sv
      - design/lambda_sampler_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_lambda_sampler.sv

/* testbench/tb_lambda_sampler.sv */
// Directed testbench for the sampling layer top level.
// A posedge model predicts every sample; a negedge checker compares lambda_out.
`timescale 1ns/1ps
`include "lambda_consts.svh"

module tb_lambda_sampler;

    logic                    clk;
    logic                    reset;
    fixed_point_pkg::fixed_t mean_in;
    fixed_point_pkg::fixed_t var_in;
    fixed_point_pkg::fixed_t lambda_out;

    int          errors;
    int          checks;
    int          pushes;
    int          seed;
    logic [15:0] lfsr_m;                       // Model generator state
    logic [15:0] expect_q [$];

    lambda_sampler_top UUT (
        .clk        (clk),
        .reset      (reset),
        .mean_in    (mean_in),
        .var_in     (var_in),
        .lambda_out (lambda_out)
    );

    always #10 clk = ~clk;

    // Slice rule: 0 below -4, pass-through from +4, else intercept + ramp
    function automatic int softplus_ref(input int x);
        int slope_tab [8];
        int icpt_tab [8];
        int idx;
        slope_tab = '{`LAMBDA_SP_SLOPE_0, `LAMBDA_SP_SLOPE_1, `LAMBDA_SP_SLOPE_2,
                      `LAMBDA_SP_SLOPE_3, `LAMBDA_SP_SLOPE_4, `LAMBDA_SP_SLOPE_5,
                      `LAMBDA_SP_SLOPE_6, `LAMBDA_SP_SLOPE_7};
        icpt_tab = '{`LAMBDA_SP_ICPT_0, `LAMBDA_SP_ICPT_1, `LAMBDA_SP_ICPT_2,
                     `LAMBDA_SP_ICPT_3, `LAMBDA_SP_ICPT_4, `LAMBDA_SP_ICPT_5,
                     `LAMBDA_SP_ICPT_6, `LAMBDA_SP_ICPT_7};
        if (x < -1024) return 0;
        if (x >= 1024) return x;
        idx = (x + 1024) / 256;
        return icpt_tab[idx] + ((slope_tab[idx] * ((x + 1024) % 256)) >> 8);
    endfunction

    // floor(sqrt(x * 256)), negatives give 0
    function automatic int isqrt_ref(input int x);
        int v;
        int r;
        int t;
        if (x <= 0) return 0;
        v = x * 256;
        r = 0;
        for (int b = 11; b >= 0; b--) begin
            t = r | (1 << b);
            if (t * t <= v) r = t;
        end
        return r;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? `LAMBDA_LFSR_TAPS : 16'h0000);
    endfunction

    function automatic int saturate(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    function automatic logic [15:0] combine_ref(input int mean, input int sigma, input int noise);
        int prod;
        prod = saturate((sigma * noise) >>> 14);
        return 16'(saturate(mean + prod));
    endfunction

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("error: %s actual 16'h%04h expected 16'h%04h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // Model: inputs sampled now are multiplied by the state five advances ahead
    always @(posedge clk) begin
        logic [15:0] s;
        int          sigma;
        if (reset) begin
            lfsr_m = `LAMBDA_LFSR_SEED;
            expect_q.delete();
        end else begin
            s = lfsr_m;
            for (int i = 0; i < 5; i++) s = lfsr_step(s);
            sigma = isqrt_ref(softplus_ref(int'(var_in)));
            expect_q.push_back(combine_ref(int'(mean_in), sigma, int'($signed(s))));
            pushes++;
            lfsr_m = lfsr_step(lfsr_m);
        end
    end

    // Output after edge n belongs to the input sampled at edge n-7
    always @(negedge clk) begin
        if (expect_q.size() == `LAMBDA_LAT) begin
            check_value("lambda_out", lambda_out, expect_q.pop_front());
            checks++;
        end else begin
            check_value("lambda_out", lambda_out, 16'h0000);   // Pipeline still empty
        end
    end

    task automatic drive_pair(input logic [15:0] m, input logic [15:0] v);
        @(posedge clk);
        mean_in <= m;
        var_in  <= v;
    endtask

    task automatic first_sample_latency();
        int cycles;
        cycles = 0;
        drive_pair(16'h0123, 16'h8000);        // sigma is 0, output is the mean
        @(negedge clk);                        // Still the driving cycle
        while (lambda_out !== 16'h0123 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (lambda_out !== 16'h0123) begin
            errors++;
            $display("Timed out waiting for the first sample after reset");
        end else begin
            check_value("latency", 16'(cycles), 16'(`LAMBDA_LAT));
        end
    endtask

    task automatic walk_means();
        drive_pair(16'h0000, 16'hF000);
        for (int i = 0; i < 16; i++) drive_pair(16'(1 << i), 16'hF000);
        drive_pair(16'hFFFF, 16'hFC00 - 16'h0001);
    endtask

    task automatic sigma_four_run();
        for (int i = 0; i < 24; i++) drive_pair(16'(i * 16'h0133 - 16'h0800), 16'h1000);
    endtask

    task automatic sweep_slices();
        for (int v = -1152; v <= 1152; v += 16) drive_pair(16'h0000, 16'(v));
        drive_pair(16'h0000, 16'h03FF);        // Last step below X_MAX
    endtask

    task automatic push_to_saturation();
        repeat (12) drive_pair(16'h7FF0, 16'h7FFF);
        repeat (12) drive_pair(16'h8000, 16'h7FFF);
    endtask

    task automatic random_stream();
        repeat (300) drive_pair(16'($random(seed)), 16'($random(seed)));
    endtask

    task automatic wait_drain();
        int target;
        int cycles;
        drive_pair(16'h0000, 16'h8000);
        @(negedge clk);
        target = pushes;
        cycles = 0;
        while (checks < target && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (checks < target) begin
            errors++;
            $display("Timed out waiting for the pipeline to drain");
        end
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        mean_in = '0;
        var_in  = 16'h8000;                    // Keeps sigma at 0 out of reset
        errors  = 0;
        checks  = 0;
        pushes  = 0;
        seed    = 32'h5055;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        first_sample_latency();
        walk_means();
        sigma_four_run();
        sweep_slices();
        push_to_saturation();
        random_stream();
        wait_drain();
        $display("Samples checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* design/lambda_sampler_top.sv */
// Top level of the sampling layer: one mean/variance pair in per cycle,
// one saturated Q8.8 sample out a fixed eight cycles later.
`timescale 1ns/1ps
`include "lambda_consts.svh"

module lambda_sampler_top (
    input  logic                    clk,
    input  logic                    reset,
    input  fixed_point_pkg::fixed_t mean_in,
    input  fixed_point_pkg::fixed_t var_in,
    output fixed_point_pkg::fixed_t lambda_out
);

    fixed_point_pkg::fixed_t softplus_var;
    fixed_point_pkg::fixed_t sigma;
    fixed_point_pkg::fixed_t mean_d;
    fixed_point_pkg::noise_t noise;
    fixed_point_pkg::noise_t noise_d;

    softplus_pwl u_softplus (.clk(clk), .reset(reset), .x(var_in), .y(softplus_var));

    sqrt_pipe u_sqrt (.clk(clk), .reset(reset), .x(softplus_var), .y(sigma));

    // Mean waits out the softplus and root stages
    delay_line #(
        .payload_t (fixed_point_pkg::fixed_t),
        .DEPTH     (`LAMBDA_LAT - `LAMBDA_COMB_LAT)
    ) u_mean_delay (.clk(clk), .reset(reset), .din(mean_in), .dout(mean_d));

    lfsr_noise u_noise (.clk(clk), .reset(reset), .noise(noise));

    delay_line #(
        .payload_t (fixed_point_pkg::noise_t),
        .DEPTH     (1)
    ) u_noise_delay (.clk(clk), .reset(reset), .din(noise), .dout(noise_d));

    reparam_combine u_combine (
        .clk    (clk),
        .reset  (reset),
        .sigma  (sigma),
        .noise  (noise_d),
        .mean   (mean_d),
        .sample (lambda_out)
    );

endmodule

/* design/reparam_combine.sv */
// Final reparameterization step: sample = mean + sigma * noise.
// Product rescaled from Q10.22 to Q8.8, both the product and the sum saturate.
`timescale 1ns/1ps

module reparam_combine (
    input  logic                    clk,
    input  logic                    reset,
    input  fixed_point_pkg::fixed_t sigma,
    input  fixed_point_pkg::noise_t noise,
    input  fixed_point_pkg::fixed_t mean,
    output fixed_point_pkg::fixed_t sample
);

    fixed_point_pkg::prod_t  prod_full;
    fixed_point_pkg::prod_t  prod_shift;
    fixed_point_pkg::fixed_t prod_sat;
    fixed_point_pkg::fixed_t prod_q;
    fixed_point_pkg::fixed_t mean_q;
    logic signed [16:0]      sum;
    fixed_point_pkg::fixed_t sum_sat;

    assign prod_full  = sigma * noise;
    assign prod_shift = prod_full >>> 14;      // Drop the noise fraction bits

    always_comb begin
        if (prod_shift > fixed_point_pkg::prod_t'(fixed_point_pkg::FIXED_MAX))
            prod_sat = fixed_point_pkg::FIXED_MAX;
        else if (prod_shift < fixed_point_pkg::prod_t'(fixed_point_pkg::FIXED_MIN))
            prod_sat = fixed_point_pkg::FIXED_MIN;
        else
            prod_sat = prod_shift[15:0];
    end

    assign sum = mean_q + prod_q;              // One guard bit for overflow

    always_comb begin
        if (sum[16] != sum[15])
            sum_sat = sum[16] ? fixed_point_pkg::FIXED_MIN : fixed_point_pkg::FIXED_MAX;
        else
            sum_sat = sum[15:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_q <= '0;
            mean_q <= '0;
            sample <= '0;
        end else begin
            prod_q <= prod_sat;
            mean_q <= mean;                    // Keeps step with the product
            sample <= sum_sat;
        end
    end

    // Any X here came from an uninitialized stage upstream
    assert property (@(posedge clk) disable iff (reset) !$isunknown(sample));

endmodule

/* design/lfsr_noise.sv */
// 16-bit Galois LFSR noise source, one Q2.14 word per cycle.
// Seeded from the constants header while reset is high.
`timescale 1ns/1ps
`include "lambda_consts.svh"

module lfsr_noise (
    input  logic                    clk,
    input  logic                    reset,
    output fixed_point_pkg::noise_t noise
);

    prng_pkg::lfsr_state_t state;
    prng_pkg::noise_bits_t view;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= `LAMBDA_LFSR_SEED;
        end else begin
            // Shift right, fold the taps back in when a 1 drops out
            state <= (state >> 1) ^ (state[0] ? `LAMBDA_LFSR_TAPS : 16'h0000);
        end
    end

    assign view  = prng_pkg::noise_bits_t'(state);
    assign noise = {view.sign, view.int_bit, view.frac};   // State bits as Q2.14

    // A zero state would lock the generator up for good
    assert property (@(posedge clk) disable iff (reset) state != '0);

endmodule

/* design/sqrt_pipe.sv */
// Pipelined integer root: y = floor(sqrt(x * 256)), giving sqrt of a Q8.8 value in Q8.8.
// Restoring digit recurrence, three root bits per stage, four stages.
`timescale 1ns/1ps

module sqrt_pipe (
    input  logic                    clk,
    input  logic                    reset,
    input  fixed_point_pkg::fixed_t x,
    output fixed_point_pkg::fixed_t y
);

    localparam int STAGES         = 4;
    localparam int BITS_PER_STAGE = 3;

    typedef struct packed {
        logic [15:0] rem;                      // Partial remainder
        logic [11:0] root;                     // Root bits resolved so far
        logic [23:0] rad;                      // Radicand bits not yet consumed
    } root_state_t;

    // Three iterations of the restoring recurrence
    function automatic root_state_t root_step(root_state_t s);
        root_state_t r;
        logic [15:0] trial;
        r = s;
        for (int i = 0; i < BITS_PER_STAGE; i++) begin
            r.rem = {r.rem[13:0], r.rad[23:22]};   // Bring down two radicand bits
            r.rad = {r.rad[21:0], 2'b00};
            trial = {2'b00, r.root, 2'b01};        // 4*root + 1
            if (r.rem >= trial) begin
                r.rem  = r.rem - trial;
                r.root = {r.root[10:0], 1'b1};
            end else begin
                r.root = {r.root[10:0], 1'b0};
            end
        end
        return r;
    endfunction

    root_state_t             st_in;
    root_state_t             st_q [STAGES];
    fixed_point_pkg::fixed_t x_q  [STAGES];   // Input carried along for the check

    assign st_in.rem  = '0;
    assign st_in.root = '0;
    assign st_in.rad  = x[15] ? 24'd0 : {x, 8'b0};  // Negative input gives 0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < STAGES; s++) begin
                st_q[s] <= '0;
                x_q[s]  <= '0;
            end
        end else begin
            st_q[0] <= root_step(st_in);
            x_q[0]  <= x;
            for (int s = 1; s < STAGES; s++) begin
                st_q[s] <= root_step(st_q[s-1]);
                x_q[s]  <= x_q[s-1];
            end
        end
    end

    assign y = fixed_point_pkg::fixed_t'({4'b0000, st_q[STAGES-1].root});

    logic [24:0] rad_chk;
    logic [12:0] root_inc;
    logic [24:0] root_sq;
    logic [24:0] root_inc_sq;

    assign rad_chk     = x_q[STAGES-1][15] ? 25'd0 : {1'b0, x_q[STAGES-1], 8'b0};
    assign root_inc    = {1'b0, st_q[STAGES-1].root} + 13'd1;
    assign root_sq     = 25'(st_q[STAGES-1].root) * 25'(st_q[STAGES-1].root);
    assign root_inc_sq = 25'(root_inc) * 25'(root_inc);

    // Output is the floor root of the input that entered four cycles earlier
    assert property (@(posedge clk) disable iff (reset)
        (root_sq <= rad_chk) && (root_inc_sq > rad_chk));

endmodule

/* design/softplus_pwl.sv */
// Eight-slice piecewise-linear softplus over [-4, +4), two register stages.
// Below the range the result is 0, at or above it the input passes through.
`timescale 1ns/1ps
`include "lambda_consts.svh"

module softplus_pwl (
    input  logic                    clk,
    input  logic                    reset,
    input  fixed_point_pkg::fixed_t x,
    output fixed_point_pkg::fixed_t y
);

    localparam logic [1:0] CLS_LOW   = 2'd0;
    localparam logic [1:0] CLS_HIGH  = 2'd1;
    localparam logic [1:0] CLS_SLICE = 2'd2;

    fixed_point_pkg::fixed_t rel;              // x relative to X_MIN
    logic [2:0]              slice;
    logic [1:0]              cls;
    fixed_point_pkg::slope_t slope;
    fixed_point_pkg::fixed_t icpt;

    // Stage 1 registers
    logic [1:0]              cls_q;
    fixed_point_pkg::fixed_t x_q;
    logic [7:0]              offset_q;
    fixed_point_pkg::slope_t slope_q;
    fixed_point_pkg::fixed_t icpt_q;

    logic [16:0]             ramp_full;
    fixed_point_pkg::fixed_t y_next;

    assign rel   = x - `LAMBDA_SP_X_MIN;
    assign slice = rel[10:8];                  // Unit-wide slices

    always_comb begin
        if (x < `LAMBDA_SP_X_MIN) cls = CLS_LOW;
        else if (x >= `LAMBDA_SP_X_MAX) cls = CLS_HIGH;
        else cls = CLS_SLICE;
    end

    always_comb begin
        case (slice)
            3'd0: begin slope = `LAMBDA_SP_SLOPE_0; icpt = `LAMBDA_SP_ICPT_0; end
            3'd1: begin slope = `LAMBDA_SP_SLOPE_1; icpt = `LAMBDA_SP_ICPT_1; end
            3'd2: begin slope = `LAMBDA_SP_SLOPE_2; icpt = `LAMBDA_SP_ICPT_2; end
            3'd3: begin slope = `LAMBDA_SP_SLOPE_3; icpt = `LAMBDA_SP_ICPT_3; end
            3'd4: begin slope = `LAMBDA_SP_SLOPE_4; icpt = `LAMBDA_SP_ICPT_4; end
            3'd5: begin slope = `LAMBDA_SP_SLOPE_5; icpt = `LAMBDA_SP_ICPT_5; end
            3'd6: begin slope = `LAMBDA_SP_SLOPE_6; icpt = `LAMBDA_SP_ICPT_6; end
            default: begin slope = `LAMBDA_SP_SLOPE_7; icpt = `LAMBDA_SP_ICPT_7; end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cls_q    <= CLS_LOW;
            x_q      <= '0;
            offset_q <= '0;
            slope_q  <= '0;
            icpt_q   <= '0;
        end else begin
            cls_q    <= cls;
            x_q      <= x;
            offset_q <= rel[7:0];              // Distance into the slice
            slope_q  <= slope;
            icpt_q   <= icpt;
        end
    end

    // Q1.8 slope times Q0.8 offset, back to Q8.8
    assign ramp_full = slope_q * offset_q;

    always_comb begin
        case (cls_q)
            CLS_HIGH:  y_next = x_q;
            CLS_SLICE: y_next = icpt_q + fixed_point_pkg::fixed_t'({7'b0, ramp_full[16:8]});
            default:   y_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) y <= '0;
        else y <= y_next;
    end

    // Softplus feeds the root, which treats negatives as 0
    assert property (@(posedge clk) disable iff (reset) y >= 0);

endmodule

/* design/delay_line.sv */
// Fixed-depth shift-register delay for any payload type.
// Used to align the mean and noise words with the sigma path.
`timescale 1ns/1ps

module delay_line #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t din,
    output payload_t dout
);

    payload_t taps [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                taps[i] <= taps[i-1];   // Shift toward the output
            end
        end
    end

    assign dout = taps[DEPTH-1];

endmodule

/* design/prng_pkg.sv */
// Types of the on-chip noise generator.
package prng_pkg;

    parameter int LFSR_W = 16;

    // Raw generator state
    typedef logic [LFSR_W-1:0] lfsr_state_t;

    // The state read as a Q2.14 word
    typedef struct packed {
        logic        sign;
        logic        int_bit;
        logic [13:0] frac;
    } noise_bits_t;

endpackage

/* design/fixed_point_pkg.sv */
// Number formats of the sampling data path.
// Referenced by scoped name from every arithmetic block.
package fixed_point_pkg;

    // Signed Q8.8 for mean, variance, softplus, sigma and the sample
    typedef logic signed [15:0] fixed_t;

    // Signed Q2.14 noise word
    typedef logic signed [15:0] noise_t;

    // Unsigned Q1.8 slice slope
    typedef logic [8:0] slope_t;

    // Wide intermediate for products before rescaling
    typedef logic signed [31:0] prod_t;

    // Saturation bounds of fixed_t
    parameter fixed_t FIXED_MAX = 16'sh7FFF;
    parameter fixed_t FIXED_MIN = 16'sh8000;

endpackage

/* design/lambda_consts.svh */
// Constants for the sampling pipeline: softplus slice table, stage latencies
// and the noise generator setup. Include wherever one of them is needed.
`ifndef LAMBDA_CONSTS_SVH
`define LAMBDA_CONSTS_SVH

`define LAMBDA_SP_X_MIN     16'shFC00   // -4.0 in Q8.8
`define LAMBDA_SP_X_MAX     16'sh0400   // +4.0 in Q8.8

// Slope per unit-wide slice, Q1.8, slice 0 starts at -4.0
`define LAMBDA_SP_SLOPE_0   9'd8
`define LAMBDA_SP_SLOPE_1   9'd20
`define LAMBDA_SP_SLOPE_2   9'd48
`define LAMBDA_SP_SLOPE_3   9'd97
`define LAMBDA_SP_SLOPE_4   9'd159
`define LAMBDA_SP_SLOPE_5   9'd208
`define LAMBDA_SP_SLOPE_6   9'd236
`define LAMBDA_SP_SLOPE_7   9'd248

// softplus() at each slice's left edge, Q8.8
`define LAMBDA_SP_ICPT_0    16'sd5
`define LAMBDA_SP_ICPT_1    16'sd12
`define LAMBDA_SP_ICPT_2    16'sd32
`define LAMBDA_SP_ICPT_3    16'sd80
`define LAMBDA_SP_ICPT_4    16'sd177
`define LAMBDA_SP_ICPT_5    16'sd336
`define LAMBDA_SP_ICPT_6    16'sd544
`define LAMBDA_SP_ICPT_7    16'sd780

`define LAMBDA_SP_LAT       2
`define LAMBDA_SQRT_LAT     4
`define LAMBDA_COMB_LAT     2
`define LAMBDA_LAT          8           // Input to lambda_out

`define LAMBDA_LFSR_SEED    16'hACE1
`define LAMBDA_LFSR_TAPS    16'hB400

`endif
